/* verilog/tag_geom_pkg.sv */
//////////////////////////////////////////////////
// tag capture word geometry
// channel, record and read-word sizes, plus the
// record union seen as channels or as read words
//////////////////////////////////////////////////

`default_nettype none

package tag_geom_pkg;

  //////////////////////////////////////////////////
  // record geometry

  // one channel sample
  localparam int chan_width = 64;
  // channels per record
  localparam int num_chans = 4;
  // one read word
  localparam int out_width = 16;
  // read words per record, 256 / 16
  localparam int words_per_rec = 16;
  // word select bits in the virtual address
  localparam int sel_width = 4;

  //////////////////////////////////////////////////
  // virtual read port

  localparam int vaddr_width = 12;
  localparam int vtag_width = 8;

  // same 256 bits, two decodes
  // channel 0 and word 0 sit in the lowest bits
  typedef union packed {
    logic [num_chans-1:0][chan_width-1:0] chan;
    logic [words_per_rec-1:0][out_width-1:0] word;
  } tag_record_u;

endpackage

`default_nettype wire

/* verilog/tag_stream_pkg.sv */
//////////////////////////////////////////////////
// tag capture stream types
// input record and the framer to store write
// command
//////////////////////////////////////////////////

`default_nettype none

package tag_stream_pkg;

  // burst address width on the write and read ports
  // covers BURST_LENGTH up to 256
  localparam int burst_addr_width = 8;

  //////////////////////////////////////////////////
  // input stream record

  // tag number plus the four channel samples
  // about 264 bits per beat
  typedef struct packed {
    logic [tag_geom_pkg::vtag_width-1:0] tag;
    tag_geom_pkg::tag_record_u rec;
  } sample_in_t;

  //////////////////////////////////////////////////
  // write command, framer to store

  // qualified by a separate wr_valid
  typedef struct packed {
    // destination tag, always in range here
    logic [tag_geom_pkg::vtag_width-1:0] tag;
    // row inside the tag burst
    logic [burst_addr_width-1:0] addr;
    // final row of the burst, sets the full flag
    logic last;
    // record payload
    tag_geom_pkg::tag_record_u rec;
  } store_wr_t;

endpackage

`default_nettype wire

/* verilog/tag_burst_framer.sv */
//////////////////////////////////////////////////
// tag burst framer
// routes input records to their tag, tracks the
// row position in each burst and holds the stream
// when the target tag is full
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tag_burst_framer #(
  parameter int NUM_TAGS = 20,
  parameter int BURST_LENGTH = 32
) (
  input wire clk,
  input wire rst,

  // input record stream
  input wire sample_valid,
  output logic sample_ready,
  input wire tag_stream_pkg::sample_in_t sample,

  // per-tag status and rearm
  input wire [NUM_TAGS-1:0] tag_full,
  input wire [NUM_TAGS-1:0] rearm,

  // write command to the store
  output logic wr_valid,
  output tag_stream_pkg::store_wr_t wr
);

  // row counter bits, BURST_LENGTH is a power of two
  localparam int addr_bits = $clog2(BURST_LENGTH);
  // tag index bits
  localparam int tag_bits = (NUM_TAGS > 1) ? $clog2(NUM_TAGS) : 1;

  // one write counter per tag
  logic [addr_bits-1:0] cnt_q [NUM_TAGS];

  logic tag_ok;
  logic [tag_bits-1:0] tag_sel;
  logic [addr_bits-1:0] cur_cnt;
  logic [NUM_TAGS-1:0] wr_hit;

  //////////////////////////////////////////////////
  // handshake and write command

  always_comb begin
    // unknown tags never stall the stream
    tag_ok = int'(sample.tag) < NUM_TAGS;
    tag_sel = sample.tag[tag_bits-1:0];
    cur_cnt = tag_ok ? cnt_q[tag_sel] : '0;

    // only the framer tests fullness
    sample_ready = tag_ok ? ~tag_full[tag_sel] : 1'b1;

    // write on the handshake cycle, dropped tags give none
    wr_valid = sample_valid & sample_ready & tag_ok;

    wr.tag = sample.tag;
    wr.addr = '0;
    wr.addr[addr_bits-1:0] = cur_cnt;
    // all ones means row BURST_LENGTH-1
    wr.last = &cur_cnt;
    wr.rec = sample.rec;

    // one-hot of the tag being written
    wr_hit = '0;
    if (wr_valid) begin
      wr_hit[tag_sel] = 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // per-tag row counters

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int t = 0; t < NUM_TAGS; t++) begin
        cnt_q[t] <= '0;
      end
    end else begin
      for (int t = 0; t < NUM_TAGS; t++) begin
        // rearm wins over a write on the same edge
        if (rearm[t]) begin
          cnt_q[t] <= '0;
        end else if (wr_hit[t]) begin
          // natural wrap to zero after the last row
          cnt_q[t] <= cnt_q[t] + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/tag_burst_store.sv */
//////////////////////////////////////////////////
// tag burst store
// one burst of records per tag, written by the
// framer and read back asynchronously, plus the
// per-tag full flags
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tag_burst_store #(
  parameter int NUM_TAGS = 20,
  parameter int BURST_LENGTH = 32
) (
  input wire clk,
  input wire rst,

  // write side
  input wire wr_valid,
  input wire tag_stream_pkg::store_wr_t wr,

  // full flags
  input wire [NUM_TAGS-1:0] rearm,
  output logic [NUM_TAGS-1:0] tag_full,

  // read side
  input wire [tag_geom_pkg::vtag_width-1:0] rd_tag,
  input wire [tag_stream_pkg::burst_addr_width-1:0] rd_addr,
  output tag_geom_pkg::tag_record_u rd_rec
);

  localparam int addr_bits = $clog2(BURST_LENGTH);
  localparam int tag_bits = (NUM_TAGS > 1) ? $clog2(NUM_TAGS) : 1;

  // record array, tag by row
  tag_geom_pkg::tag_record_u mem [NUM_TAGS][BURST_LENGTH];

  logic [NUM_TAGS-1:0] full_q;
  logic [NUM_TAGS-1:0] set_full;

  //////////////////////////////////////////////////
  // record array

  // synchronous write, no reset on contents
  always_ff @(posedge clk) begin
    if (wr_valid) begin
      mem[wr.tag[tag_bits-1:0]][wr.addr[addr_bits-1:0]] <= wr.rec;
    end
  end

  // asynchronous read
  // an out of range tag reads garbage, the reader drops it
  assign rd_rec = mem[rd_tag[tag_bits-1:0]][rd_addr[addr_bits-1:0]];

  //////////////////////////////////////////////////
  // full flags

  // last row of a burst marks its tag full
  always_comb begin
    set_full = '0;
    if (wr_valid && wr.last) begin
      set_full[wr.tag[tag_bits-1:0]] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      full_q <= '0;
    end else begin
      // rearm has priority over a completing write
      full_q <= (full_q | set_full) & ~rearm;
    end
  end

  assign tag_full = full_q;

endmodule

`default_nettype wire

/* verilog/tag_data_reader.sv */
//////////////////////////////////////////////////
// tag data reader
// decodes the virtual read address and returns one
// 16-bit word of a stored record, one cycle later
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tag_data_reader #(
  parameter int NUM_TAGS = 20,
  parameter int BURST_LENGTH = 32
) (
  input wire clk,
  input wire rst,

  // virtual read port
  input wire [tag_geom_pkg::vtag_width-1:0] virt_tagn,
  input wire [tag_geom_pkg::vaddr_width-1:0] virt_addr,

  // record lookup in the store
  output logic [tag_geom_pkg::vtag_width-1:0] rd_tag,
  output logic [tag_stream_pkg::burst_addr_width-1:0] rd_addr,
  input wire tag_geom_pkg::tag_record_u rd_rec,

  // registered read word
  output logic [tag_geom_pkg::out_width-1:0] data_out
);

  // burst row bits above the word select
  localparam int addr_bits = $clog2(BURST_LENGTH);

  logic [tag_geom_pkg::sel_width-1:0] word_sel;
  logic [tag_geom_pkg::out_width-1:0] word;
  logic tag_ok;
  logic [tag_geom_pkg::out_width-1:0] data_q;

  //////////////////////////////////////////////////
  // address decode

  always_comb begin
    // low nibble picks the word in the record
    word_sel = virt_addr[tag_geom_pkg::sel_width-1:0];

    // next bits pick the row, higher bits ignored
    rd_addr = '0;
    rd_addr[addr_bits-1:0] = virt_addr[tag_geom_pkg::sel_width +: addr_bits];
    rd_tag = virt_tagn;

    // range check lives here only
    tag_ok = int'(virt_tagn) < NUM_TAGS;

    // word view of the returned record
    word = rd_rec.word[word_sel];
  end

  //////////////////////////////////////////////////
  // output register

  // zero for reset or an unknown tag
  always_ff @(posedge clk) begin
    if (rst || !tag_ok) begin
      data_q <= '0;
    end else begin
      data_q <= word;
    end
  end

  assign data_out = data_q;

endmodule

`default_nettype wire

/* verilog/tag_data_collector.sv */
//////////////////////////////////////////////////
// multi-tag burst capture, top level
// framer, per-tag burst store and virtual address
// reader
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tag_data_collector #(
  parameter int NUM_TAGS = 20,
  parameter int BURST_LENGTH = 32
) (
  input wire clk,
  input wire rst,

  // input record stream
  input wire sample_valid,
  output logic sample_ready,
  input wire tag_stream_pkg::sample_in_t sample,

  // burst control and status
  input wire [NUM_TAGS-1:0] rearm,
  output logic [NUM_TAGS-1:0] burst_done,

  // virtual read port
  input wire [tag_geom_pkg::vtag_width-1:0] virt_tagn,
  input wire [tag_geom_pkg::vaddr_width-1:0] virt_addr,
  output logic [tag_geom_pkg::out_width-1:0] data_out
);

  // framer to store
  logic wr_valid;
  tag_stream_pkg::store_wr_t wr;
  logic [NUM_TAGS-1:0] tag_full;

  // reader to store
  logic [tag_geom_pkg::vtag_width-1:0] rd_tag;
  logic [tag_stream_pkg::burst_addr_width-1:0] rd_addr;
  tag_geom_pkg::tag_record_u rd_rec;

  //////////////////////////////////////////////////
  // write path

  tag_burst_framer #(
    .NUM_TAGS     (NUM_TAGS),
    .BURST_LENGTH (BURST_LENGTH)
  ) framer0 (
    .clk          (clk),
    .rst          (rst),
    .sample_valid (sample_valid),
    .sample_ready (sample_ready),
    .sample       (sample),
    .tag_full     (tag_full),
    .rearm        (rearm),
    .wr_valid     (wr_valid),
    .wr           (wr)
  );

  tag_burst_store #(
    .NUM_TAGS     (NUM_TAGS),
    .BURST_LENGTH (BURST_LENGTH)
  ) store0 (
    .clk      (clk),
    .rst      (rst),
    .wr_valid (wr_valid),
    .wr       (wr),
    .rearm    (rearm),
    .tag_full (tag_full),
    .rd_tag   (rd_tag),
    .rd_addr  (rd_addr),
    .rd_rec   (rd_rec)
  );

  // full flags double as burst completion status
  assign burst_done = tag_full;

  //////////////////////////////////////////////////
  // read path

  tag_data_reader #(
    .NUM_TAGS     (NUM_TAGS),
    .BURST_LENGTH (BURST_LENGTH)
  ) reader0 (
    .clk       (clk),
    .rst       (rst),
    .virt_tagn (virt_tagn),
    .virt_addr (virt_addr),
    .rd_tag    (rd_tag),
    .rd_addr   (rd_addr),
    .rd_rec    (rd_rec),
    .data_out  (data_out)
  );

endmodule

`default_nettype wire

/* test/tag_data_collector_tb.sv */
//////////////////////////////////////////////////
// testbench for the multi-tag burst capture top
// table of writes, reads, stalls and rearms,
// checked against a per-tag model of the bursts
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tag_data_collector_tb;

  localparam int num_tags = 4;
  localparam int burst_len = 8;
  // cycles a record may wait for sample_ready
  localparam int ready_limit = 40;

  // table entry kinds
  localparam logic [2:0] k_write = 3'd0;
  localparam logic [2:0] k_read = 3'd1;
  localparam logic [2:0] k_rearm = 3'd2;
  localparam logic [2:0] k_idle = 3'd3;
  localparam logic [2:0] k_stall = 3'd4;

  // count is the seed step, read length, stall or idle cycles
  typedef struct packed {
    logic [2:0] kind;
    logic [7:0] tag;
    logic [11:0] addr;
    logic [15:0] count;
    logic [num_tags-1:0] mask;
    logic zero_src;
  } step_t;

  logic clk;
  logic rst;
  logic sample_valid;
  logic sample_ready;
  tag_stream_pkg::sample_in_t sample;
  logic [num_tags-1:0] rearm;
  logic [num_tags-1:0] burst_done;
  logic [tag_geom_pkg::vtag_width-1:0] virt_tagn;
  logic [tag_geom_pkg::vaddr_width-1:0] virt_addr;
  logic [tag_geom_pkg::out_width-1:0] data_out;

  step_t steps[$];
  // model of accepted records by tag, row and channel
  logic [63:0] model_mem [num_tags][burst_len][4];
  int model_cnt [num_tags];
  logic [num_tags-1:0] model_full;
  logic [31:0] rng_state;
  tag_stream_pkg::sample_in_t pend_rec;
  logic held;
  logic timed_out;
  int checks;
  int errors;
  int timeouts;

  tag_data_collector #(
    .NUM_TAGS     (num_tags),
    .BURST_LENGTH (burst_len)
  ) dut0 (
    .clk          (clk),
    .rst          (rst),
    .sample_valid (sample_valid),
    .sample_ready (sample_ready),
    .sample       (sample),
    .rearm        (rearm),
    .burst_done   (burst_done),
    .virt_tagn    (virt_tagn),
    .virt_addr    (virt_addr),
    .data_out     (data_out)
  );

  // 100 ns clock
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // model helpers

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // word n is bits 16n..16n+15 with channel 0 lowest
  function automatic logic [15:0] model_word(input int tag, input logic [11:0] addr);
    logic [255:0] flat;
    int row;
    // row sits above the word select and higher bits are ignored
    row = int'(addr[11:4]) % burst_len;
    flat = {model_mem[tag][row][3], model_mem[tag][row][2],
            model_mem[tag][row][1], model_mem[tag][row][0]};
    return flat[16*int'(addr[3:0]) +: 16];
  endfunction

  function automatic step_t make_step(input logic [2:0] kind, input int tag, input int addr,
                                      input int count, input int mask, input logic zero_src);
    step_t s;
    s.kind = kind;
    s.tag = 8'(tag);
    s.addr = 12'(addr);
    s.count = 16'(count);
    s.mask = num_tags'(mask);
    s.zero_src = zero_src;
    return s;
  endfunction

  task automatic check_value(input string name, input logic [15:0] exp_v,
                             input logic [15:0] got_v);
    checks++;
    if (got_v !== exp_v) begin
      $display("[FAIL] %0t %s exp 0x%04h got 0x%04h", $time, name, exp_v, got_v);
      errors++;
    end
  endtask

  //////////////////////////////////////////////////
  // stream side

  // draws four channels and holds them on the stream
  task automatic present_record(input logic [7:0] tag, input int step);
    tag_stream_pkg::sample_in_t s;
    for (int i = 0; i < step; i++) begin
      rng_state = lcg_next(rng_state);
    end
    s.tag = tag;
    for (int c = 0; c < 4; c++) begin
      rng_state = lcg_next(rng_state);
      s.rec.chan[c][63:32] = rng_state;
      rng_state = lcg_next(rng_state);
      s.rec.chan[c][31:0] = rng_state;
    end
    pend_rec = s;
    @(posedge clk);
    sample_valid <= 1'b1;
    sample <= s;
  endtask

  // waits for ready, takes the handshake edge and updates the model
  task automatic finish_handshake();
    int waited;
    int t;
    waited = 0;
    t = int'(pend_rec.tag);
    @(negedge clk);
    while (!sample_ready && waited < ready_limit) begin
      @(negedge clk);
      waited++;
    end
    if (!sample_ready) begin
      $display("timeout: record for tag %0d not accepted after %0d cycles at %0t",
               t, waited, $time);
      timeouts++;
      timed_out = 1'b1;
    end else begin
      @(posedge clk);
      sample_valid <= 1'b0;
      held = 1'b0;
      // unknown tags are acknowledged and dropped
      if (t < num_tags) begin
        for (int c = 0; c < 4; c++) begin
          model_mem[t][model_cnt[t]][c] = pend_rec.rec.chan[c];
        end
        if (model_cnt[t] == burst_len - 1) begin
          model_full[t] = 1'b1;
        end
        model_cnt[t] = (model_cnt[t] + 1) % burst_len;
      end
      @(negedge clk);
      check_value("burst_done", 16'(model_full), 16'(burst_done));
    end
  endtask

  // ready must stay low while the tag is full
  task automatic expect_stall(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk);
      check_value("sample_ready", 16'h0, 16'(sample_ready));
    end
  endtask

  task automatic pulse_rearm(input logic [num_tags-1:0] mask);
    @(posedge clk);
    rearm <= mask;
    @(posedge clk);
    rearm <= '0;
    for (int t = 0; t < num_tags; t++) begin
      if (mask[t]) begin
        model_cnt[t] = 0;
        model_full[t] = 1'b0;
      end
    end
    // a held record goes in right after the rearm edge
    if (held) begin
      finish_handshake();
    end else begin
      @(negedge clk);
      check_value("burst_done", 16'(model_full), 16'(burst_done));
    end
  endtask

  //////////////////////////////////////////////////
  // read side

  // one address per cycle with each word checked one edge later
  task automatic read_words(input logic [7:0] tag, input logic [11:0] start,
                            input int count, input logic zero_src);
    logic [11:0] addr;
    logic [11:0] prev_addr;
    logic [15:0] exp_word;
    logic [15:0] prev_word;
    addr = start;
    prev_addr = start;
    exp_word = '0;
    prev_word = '0;
    for (int i = 0; i <= count; i++) begin
      @(posedge clk);
      if (i < count) begin
        addr = start + 12'(i);
        virt_tagn <= tag;
        virt_addr <= addr;
        exp_word = zero_src ? 16'h0 : model_word(int'(tag), addr);
      end
      @(negedge clk);
      if (i > 0) begin
        checks++;
        if (data_out !== prev_word) begin
          $display("[FAIL] %0t data_out tag %0d addr 0x%03h exp 0x%04h got 0x%04h",
                   $time, tag, prev_addr, prev_word, data_out);
          errors++;
        end
      end
      prev_word = exp_word;
      prev_addr = addr;
    end
  endtask

  task automatic apply_step(input step_t s);
    case (s.kind)
      k_write: begin
        present_record(s.tag, int'(s.count));
        finish_handshake();
      end
      k_read: read_words(s.tag, s.addr, int'(s.count), s.zero_src);
      k_rearm: pulse_rearm(s.mask);
      k_stall: begin
        present_record(s.tag, 1);
        expect_stall(int'(s.count));
        held = 1'b1;
      end
      default: repeat (int'(s.count)) @(posedge clk);
    endcase
  endtask

  //////////////////////////////////////////////////
  // stimulus table and main sequence

  initial begin
    rst <= 1'b1;
    sample_valid <= 1'b0;
    sample <= '0;
    rearm <= '0;
    virt_tagn <= '0;
    virt_addr <= '0;
    rng_state = 32'hcae3_3b5c;
    model_full = '0;
    held = 1'b0;
    timed_out = 1'b0;
    checks = 0;
    errors = 0;
    timeouts = 0;
    for (int t = 0; t < num_tags; t++) begin
      model_cnt[t] = 0;
    end

    // interleaved bursts with one record per tag per row
    for (int row = 0; row < burst_len; row++) begin
      for (int t = 0; t < num_tags; t++) begin
        steps.push_back(make_step(k_write, t, 0, (row + t) % 3, 0, 1'b0));
      end
    end
    steps.push_back(make_step(k_idle, 0, 0, 2, 0, 1'b0));
    // tag 5 does not exist and is accepted without a write
    steps.push_back(make_step(k_write, 5, 0, 1, 0, 1'b0));
    for (int t = 0; t < num_tags; t++) begin
      steps.push_back(make_step(k_read, t, 0, burst_len * 16, 0, 1'b0));
    end
    // high address bits alias onto row 0
    steps.push_back(make_step(k_read, 1, 12'hf80, 16, 0, 1'b0));
    steps.push_back(make_step(k_read, 4, 0, 4, 0, 1'b1));
    steps.push_back(make_step(k_read, 255, 12'h0a5, 4, 0, 1'b1));
    // back-pressure on tag 2 then rearm and overwrite from row 0
    steps.push_back(make_step(k_stall, 2, 0, 12, 0, 1'b0));
    steps.push_back(make_step(k_rearm, 0, 0, 0, 4'b0100, 1'b0));
    for (int i = 0; i < 4; i++) begin
      steps.push_back(make_step(k_write, 2, 0, 2, 0, 1'b0));
    end
    for (int t = 0; t < num_tags; t++) begin
      steps.push_back(make_step(k_read, t, 0, burst_len * 16, 0, 1'b0));
    end
    steps.push_back(make_step(k_read, 200, 0, 2, 0, 1'b1));
    // rearm of tag 0 with no record waiting
    steps.push_back(make_step(k_rearm, 0, 0, 0, 4'b0001, 1'b0));

    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_value("data_out", 16'h0, data_out);
    check_value("burst_done", 16'h0, 16'(burst_done));
    check_value("sample_ready", 16'h1, 16'(sample_ready));

    foreach (steps[i]) begin
      if (!timed_out) begin
        apply_step(steps[i]);
      end
    end

    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
verilog/tag_geom_pkg.sv
verilog/tag_stream_pkg.sv
verilog/tag_burst_framer.sv
verilog/tag_burst_store.sv
verilog/tag_data_reader.sv
verilog/tag_data_collector.sv
test/tag_data_collector_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the burst capture testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module tag_data_collector_tb \
  -f project.f

sim_status=0
./obj_dir/Vtag_data_collector_tb > sim.log 2>&1 || sim_status=$?
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
  exit 1
fi
if [ "$sim_status" -ne 0 ]; then
  exit "$sim_status"
fi
grep -q "Simulation PASSED" sim.log
